// ==== rtl/capture_consts.svh ====
/*
 * size constants for the sparse capture unit
 * channel count, sample and timestamp widths, buffer depths, bus widths
 */
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// channels and sample format
`define CAP_N_CHANNELS 2
`define CAP_SAMPLE_WIDTH 16

// per-channel buffer depths
`define CAP_DATA_DEPTH 64
`define CAP_TS_DEPTH 16

// timestamp = {timer, saved-sample index}, 32 bits total
`define CAP_TIMER_WIDTH 24
`define CAP_INDEX_WIDTH 8

// wishbone word address and data widths
`define CAP_WB_ADDR_WIDTH 3
`define CAP_WB_DATA_WIDTH 32

`endif

// ==== rtl/capture_pkg.sv ====
/*
 * shared types for the sparse capture unit
 * state, field and register enums, structs passed between modules
 */
`include "capture_consts.svh"

package capture_pkg;

  // derived widths
  localparam int CH_W = $clog2(`CAP_N_CHANNELS);
  localparam int DATA_AW = $clog2(`CAP_DATA_DEPTH);
  localparam int TS_AW = $clog2(`CAP_TS_DEPTH);
  localparam int TS_W = `CAP_TIMER_WIDTH + `CAP_INDEX_WIDTH;
  localparam int SCNT_W = `CAP_INDEX_WIDTH;
  localparam int TCNT_W = TS_AW + 1;

  // top-level state, also what the status register returns
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CAPTURE,
    ST_READ_TS,
    ST_READ_DATA,
    ST_DONE
  } ctrl_state_e;

  // which word of a channel section the readout is on
  typedef enum logic [1:0] {
    F_CHANNEL,
    F_COUNT,
    F_ENTRY
  } read_field_e;

  // register map
  typedef enum logic [`CAP_WB_ADDR_WIDTH-1:0] {
    A_CONTROL = 3'd0,
    A_STATUS  = 3'd1,
    A_THRESH0 = 3'd2,
    A_THRESH1 = 3'd3,
    A_READOUT = 3'd4
  } reg_addr_e;

  typedef struct packed {
    logic                         valid;
    logic [`CAP_SAMPLE_WIDTH-1:0] sample;
  } sample_in_t;

  typedef struct packed {
    logic [`CAP_SAMPLE_WIDTH-1:0] high;
    logic [`CAP_SAMPLE_WIDTH-1:0] low;
  } thresholds_t;

  // one write into a channel buffer, sample and timestamp side
  typedef struct packed {
    logic                         sample_we;
    logic [DATA_AW-1:0]           sample_addr;
    logic [`CAP_SAMPLE_WIDTH-1:0] sample;
    logic                         ts_we;
    logic [TS_AW-1:0]             ts_addr;
    logic [TS_W-1:0]              ts;
  } buf_wr_t;

  typedef struct packed {
    logic [SCNT_W-1:0] n_samples;
    logic [TCNT_W-1:0] n_ts;
  } fill_counts_t;

  // phase 0 is timestamps, phase 1 is data
  typedef struct packed {
    logic [CH_W-1:0]    channel;
    logic               phase;
    read_field_e        field;
    logic [DATA_AW-1:0] index;
  } read_pos_t;

endpackage

// ==== rtl/hysteresis_discriminator.sv ====
/*
 * per-channel hysteresis discriminator
 * threshold compare, is_high state, accepted-sample timer, fill counts
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module hysteresis_discriminator import capture_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         clear,
  input  logic         capture,
  input  sample_in_t   sample_in,
  input  thresholds_t  thresholds,
  output buf_wr_t      wr,
  output fill_counts_t counts
);

  logic                        is_high;
  logic                        high_next;
  logic                        accept;
  logic                        save;
  logic                        save_ts;
  logic [`CAP_TIMER_WIDTH-1:0] timer;
  logic [SCNT_W-1:0]           n_samples;
  logic [TCNT_W-1:0]           n_ts;

  // samples only count while capture runs
  assign accept = capture && sample_in.valid;

  // above high sets, below low clears, in between holds
  always_comb begin
    if (sample_in.sample > thresholds.high) begin
      high_next = 1'b1;
    end else if (sample_in.sample < thresholds.low) begin
      high_next = 1'b0;
    end else begin
      high_next = is_high;
    end
  end

  assign save = accept && high_next && (n_samples < `CAP_DATA_DEPTH);
  // rising edge of is_high starts a burst
  assign save_ts = save && !is_high && (n_ts < `CAP_TS_DEPTH);

  //////////////////////////////
  // buffer write request
  //////////////////////////////
  assign wr.sample_we = save;
  assign wr.sample_addr = n_samples[DATA_AW-1:0];
  assign wr.sample = sample_in.sample;
  assign wr.ts_we = save_ts;
  assign wr.ts_addr = n_ts[TS_AW-1:0];
  // timer and index before this sample
  assign wr.ts = {timer, n_samples};

  assign counts.n_samples = n_samples;
  assign counts.n_ts = n_ts;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      is_high <= 1'b0;
      timer <= '0;
      n_samples <= '0;
      n_ts <= '0;
    end else if (accept) begin
      is_high <= high_next;
      timer <= timer + 1'b1;
      if (save) begin
        n_samples <= n_samples + 1'b1;
      end
      if (save_ts) begin
        n_ts <= n_ts + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/channel_buffer.sv ====
/*
 * per-channel storage
 * sample memory and timestamp memory with registered reads
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module channel_buffer import capture_pkg::*; (
  input  logic                         clk,
  input  buf_wr_t                      wr,
  input  logic [DATA_AW-1:0]           rd_index,
  output logic [TS_W-1:0]              ts_rd,
  output logic [`CAP_SAMPLE_WIDTH-1:0] sample_rd
);

  logic [`CAP_SAMPLE_WIDTH-1:0] data_mem [`CAP_DATA_DEPTH];
  logic [TS_W-1:0]              ts_mem [`CAP_TS_DEPTH];

  // write side, one port per memory
  always_ff @(posedge clk) begin
    if (wr.sample_we) begin
      data_mem[wr.sample_addr] <= wr.sample;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.ts_we) begin
      ts_mem[wr.ts_addr] <= wr.ts;
    end
  end

  // read side, one cycle latency
  // timestamp memory is shallower, so only the low index bits address it
  always_ff @(posedge clk) begin
    sample_rd <= data_mem[rd_index];
    ts_rd <= ts_mem[rd_index[TS_AW-1:0]];
  end

endmodule

// ==== rtl/readout_counter.sv ====
/*
 * readout position counter
 * walks phase, channel, field and entry index over the readout sequence
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module readout_counter import capture_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         begin_phase,
  input  logic         step,
  input  fill_counts_t counts [`CAP_N_CHANNELS],
  output read_pos_t    pos,
  output logic         last
);

  logic [SCNT_W-1:0] cur_count;
  logic [SCNT_W-1:0] idx_plus;
  logic              entries_done;
  logic              last_channel;

  // entry count of the section being read
  assign cur_count = pos.phase ? counts[pos.channel].n_samples :
                                 SCNT_W'(counts[pos.channel].n_ts);
  assign idx_plus = SCNT_W'(pos.index) + 1'b1;

  // this word closes the channel section
  // empty sections end at the count word
  assign entries_done = (pos.field == F_COUNT && cur_count == '0) ||
                        (pos.field == F_ENTRY && idx_plus == cur_count);
  assign last_channel = pos.channel == CH_W'(`CAP_N_CHANNELS - 1);

  // final word of the data phase
  assign last = pos.phase && last_channel && entries_done;

  always_ff @(posedge clk) begin
    if (reset || begin_phase) begin
      pos <= '0;
    end else if (step) begin
      if (entries_done) begin
        // next channel header, wrap into the data phase
        pos.field <= F_CHANNEL;
        pos.index <= '0;
        if (last_channel) begin
          pos.channel <= '0;
          pos.phase <= 1'b1;
        end else begin
          pos.channel <= pos.channel + 1'b1;
        end
      end else if (pos.field == F_CHANNEL) begin
        pos.field <= F_COUNT;
      end else if (pos.field == F_COUNT) begin
        pos.field <= F_ENTRY;
        pos.index <= '0;
      end else begin
        pos.index <= pos.index + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/capture_control.sv ====
/*
 * capture and readout sequencing
 * top FSM, clear and step pulses, readout word mux and output register
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module capture_control import capture_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          stop,
  input  logic                          read_req,
  input  read_pos_t                     pos,
  input  logic                          last,
  input  fill_counts_t                  counts [`CAP_N_CHANNELS],
  input  logic [TS_W-1:0]               ts_rd [`CAP_N_CHANNELS],
  input  logic [`CAP_SAMPLE_WIDTH-1:0]  sample_rd [`CAP_N_CHANNELS],
  output ctrl_state_e                   state,
  output logic                          clear,
  output logic                          capture,
  output logic                          step,
  output logic [`CAP_WB_DATA_WIDTH-1:0] word,
  output logic                          word_valid
);

  logic                          reading;
  logic                          rd_pend;
  logic                          rd_live;
  read_pos_t                     pos_q;
  logic [CH_W-1:0]               ch;
  logic [`CAP_WB_DATA_WIDTH-1:0] word_next;

  assign reading = (state == ST_READ_TS) || (state == ST_READ_DATA);

  // start only counts from idle or done
  assign clear = start && (state == ST_IDLE || state == ST_DONE);
  assign capture = state == ST_CAPTURE;
  // each bus read moves the counter one word on
  assign step = read_req && reading;

  //////////////////////////////
  // state machine
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_DONE: begin
          if (start) begin
            state <= ST_CAPTURE;
          end
        end
        ST_CAPTURE: begin
          if (stop) begin
            state <= ST_READ_TS;
          end
        end
        // the counter flips its phase bit after the last timestamp word
        ST_READ_TS: begin
          if (pos.phase) begin
            state <= ST_READ_DATA;
          end
        end
        ST_READ_DATA: begin
          if (step && last) begin
            state <= ST_DONE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // read pipeline
  //////////////////////////////
  // cycle 0 has read_req high while buffers and pos_q load
  // cycle 1 loads the word register from the mux
  // cycle 2 raises word_valid
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pend <= 1'b0;
      rd_live <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      rd_pend <= read_req;
      word_valid <= rd_pend;
      if (read_req) begin
        rd_live <= reading;
      end
    end
  end

  // position copy lines up with the buffer read data
  always_ff @(posedge clk) begin
    if (read_req) begin
      pos_q <= pos;
    end
  end

  assign ch = pos_q.channel;

  always_comb begin
    case (pos_q.field)
      F_CHANNEL: word_next = `CAP_WB_DATA_WIDTH'(pos_q.channel);
      F_COUNT: begin
        if (pos_q.phase) begin
          word_next = `CAP_WB_DATA_WIDTH'(counts[ch].n_samples);
        end else begin
          word_next = `CAP_WB_DATA_WIDTH'(counts[ch].n_ts);
        end
      end
      F_ENTRY: begin
        if (pos_q.phase) begin
          word_next = `CAP_WB_DATA_WIDTH'(sample_rd[ch]);
        end else begin
          word_next = `CAP_WB_DATA_WIDTH'(ts_rd[ch]);
        end
      end
      default: word_next = '0;
    endcase
  end

  // reads outside the readout phases return zero
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      word <= rd_live ? word_next : '0;
    end
  end

endmodule

// ==== rtl/wb_capture_regs.sv ====
/*
 * wishbone classic slave for the capture unit
 * register decode, threshold registers, control and readout pulses
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module wb_capture_regs import capture_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`CAP_WB_ADDR_WIDTH-1:0] wb_adr,
  input  logic [`CAP_WB_DATA_WIDTH-1:0] wb_dat_w,
  output logic [`CAP_WB_DATA_WIDTH-1:0] wb_dat_r,
  output logic                          wb_ack,
  input  ctrl_state_e                   state,
  input  logic [`CAP_WB_DATA_WIDTH-1:0] word,
  input  logic                          word_valid,
  output thresholds_t                   thresholds [`CAP_N_CHANNELS],
  output logic                          start,
  output logic                          stop,
  output logic                          read_req
);

  reg_addr_e                     addr;
  logic                          access;
  logic                          rd_busy;
  logic [`CAP_WB_DATA_WIDTH-1:0] reg_rdata;

  assign addr = reg_addr_e'(wb_adr);
  // new cycle seen, not the tail of one already acked
  assign access = wb_cyc && wb_stb && !wb_ack && !rd_busy;

  always_comb begin
    case (addr)
      A_STATUS:  reg_rdata = `CAP_WB_DATA_WIDTH'(state);
      A_THRESH0: reg_rdata = thresholds[0];
      A_THRESH1: reg_rdata = thresholds[1];
      default:   reg_rdata = '0;
    endcase
  end

  //////////////////////////////
  // ack, pulses, thresholds
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      rd_busy <= 1'b0;
      start <= 1'b0;
      stop <= 1'b0;
      read_req <= 1'b0;
      for (int i = 0; i < `CAP_N_CHANNELS; i++) begin
        thresholds[i] <= '0;
      end
    end else begin
      wb_ack <= 1'b0;
      start <= 1'b0;
      stop <= 1'b0;
      read_req <= 1'b0;
      if (rd_busy) begin
        // readout read waits for the control side word
        if (word_valid) begin
          wb_ack <= 1'b1;
          rd_busy <= 1'b0;
        end
      end else if (access) begin
        if (!wb_we && addr == A_READOUT) begin
          read_req <= 1'b1;
          rd_busy <= 1'b1;
        end else begin
          wb_ack <= 1'b1;
          if (wb_we) begin
            case (addr)
              A_CONTROL: begin
                start <= wb_dat_w[0];
                stop <= wb_dat_w[1];
              end
              A_THRESH0: thresholds[0] <= thresholds_t'(wb_dat_w);
              A_THRESH1: thresholds[1] <= thresholds_t'(wb_dat_w);
              default: ;
            endcase
          end
        end
      end
    end
  end

  // read data, register reads or the returned readout word
  always_ff @(posedge clk) begin
    if (rd_busy && word_valid) begin
      wb_dat_r <= word;
    end else if (access && !wb_we) begin
      wb_dat_r <= reg_rdata;
    end
  end

endmodule

// ==== rtl/sparse_capture_top.sv ====
/*
 * sparse capture unit top level
 * bus slave, control FSM, readout counter, per-channel discriminator and buffer
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module sparse_capture_top import capture_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`CAP_WB_ADDR_WIDTH-1:0] wb_adr,
  input  logic [`CAP_WB_DATA_WIDTH-1:0] wb_dat_w,
  output logic [`CAP_WB_DATA_WIDTH-1:0] wb_dat_r,
  output logic                          wb_ack,
  input  sample_in_t                    sample_in [`CAP_N_CHANNELS]
);

  thresholds_t                   thresholds [`CAP_N_CHANNELS];
  fill_counts_t                  counts [`CAP_N_CHANNELS];
  buf_wr_t                       buf_wr [`CAP_N_CHANNELS];
  logic [TS_W-1:0]               ts_rd [`CAP_N_CHANNELS];
  logic [`CAP_SAMPLE_WIDTH-1:0]  sample_rd [`CAP_N_CHANNELS];
  ctrl_state_e                   state;
  read_pos_t                     pos;
  logic [`CAP_WB_DATA_WIDTH-1:0] word;
  logic                          word_valid;
  logic                          start;
  logic                          stop;
  logic                          read_req;
  logic                          clear;
  logic                          capture;
  logic                          step;
  logic                          last;

  wb_capture_regs u_regs (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .state, .word, .word_valid,
    .thresholds, .start, .stop, .read_req
  );

  capture_control u_ctrl (
    .clk, .reset, .start, .stop, .read_req,
    .pos, .last, .counts, .ts_rd, .sample_rd,
    .state, .clear, .capture, .step, .word, .word_valid
  );

  // counter rewinds on the same pulse that clears the channels
  readout_counter u_cnt (
    .clk, .reset, .begin_phase(clear), .step, .counts, .pos, .last
  );

  ////////////////////////////////
  // per-channel datapath
  ////////////////////////////////
  for (genvar i = 0; i < `CAP_N_CHANNELS; i++) begin : g_chan
    hysteresis_discriminator u_disc (
      .clk, .reset, .clear, .capture,
      .sample_in(sample_in[i]), .thresholds(thresholds[i]),
      .wr(buf_wr[i]), .counts(counts[i])
    );

    channel_buffer u_buf (
      .clk, .wr(buf_wr[i]), .rd_index(pos.index),
      .ts_rd(ts_rd[i]), .sample_rd(sample_rd[i])
    );
  end

endmodule

// ==== tb/tb_sparse_capture.sv ====
/*
 * testbench for the sparse capture unit
 * clock and reset, lfsr stimulus, wishbone bus tasks,
 * reference model of the save rule, readout checks
 */
`timescale 1ns/1ps
`include "capture_consts.svh"

module tb_sparse_capture import capture_pkg::*; ();

  localparam int ACK_TIMEOUT = 64;
  localparam int STATE_TIMEOUT = 32;
  // stimulus modes
  localparam int M_ALL_HIGH = 0;
  localparam int M_ALL_LOW = 1;
  localparam int M_STRADDLE = 2;
  localparam int M_GAPS = 3;

  logic                          clk;
  logic                          reset;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [`CAP_WB_ADDR_WIDTH-1:0] wb_adr;
  logic [`CAP_WB_DATA_WIDTH-1:0] wb_dat_w;
  logic [`CAP_WB_DATA_WIDTH-1:0] wb_dat_r;
  logic                          wb_ack;
  sample_in_t                    sample_in [`CAP_N_CHANNELS];

  logic [15:0] lfsr_q;
  int          errors;

  // reference model state, per channel
  logic [15:0] thr_high [`CAP_N_CHANNELS];
  logic [15:0] thr_low [`CAP_N_CHANNELS];
  logic        is_high_m [`CAP_N_CHANNELS];
  int          timer_m [`CAP_N_CHANNELS];
  int          n_samp_m [`CAP_N_CHANNELS];
  int          n_ts_m [`CAP_N_CHANNELS];
  logic [31:0] exp_ts [`CAP_N_CHANNELS][`CAP_TS_DEPTH];
  logic [15:0] exp_data [`CAP_N_CHANNELS][`CAP_DATA_DEPTH];
  // expected readout sequence, both phases
  logic [31:0] exp_words [256];
  int          n_exp;

  sparse_capture_top uut (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .sample_in
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // random bits
  //////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    logic        fb;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v = {v[14:0], fb};
    end
    return v;
  endfunction

  //////////////////////////////
  // failure reporting
  //////////////////////////////
  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "readback mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t ns: %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "wait loop expired");
  endtask

  //////////////////////////////
  // wishbone master
  //////////////////////////////
  // drive on the falling edge, hold until ack, then release
  task automatic bus_cycle(input logic we, input reg_addr_e adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    waited = 0;
    @(negedge clk);
    while (!wb_ack) begin
      if (waited == ACK_TIMEOUT) begin
        report_timeout("no wishbone ack for an outstanding bus cycle");
      end
      waited++;
      @(negedge clk);
    end
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_write(input reg_addr_e adr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdata, unused);
  endtask

  task automatic bus_read(input reg_addr_e adr, output logic [31:0] rdata);
    bus_cycle(1'b0, adr, 32'd0, rdata);
  endtask

  // poll status until the FSM reaches a state
  task automatic wait_state(input ctrl_state_e want);
    logic [31:0] st;
    int          polls;
    polls = 0;
    bus_read(A_STATUS, st);
    while (st != 32'(want)) begin
      if (polls == STATE_TIMEOUT) begin
        report_timeout("status register never reached the expected state");
      end
      polls++;
      bus_read(A_STATUS, st);
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic void model_clear();
    int ch;
    for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
      is_high_m[ch] = 1'b0;
      timer_m[ch] = 0;
      n_samp_m[ch] = 0;
      n_ts_m[ch] = 0;
    end
  endfunction

  // one accepted sample on one channel
  function automatic void model_sample(input int ch, input logic [15:0] s);
    logic next_high;
    next_high = is_high_m[ch];
    if (s > thr_high[ch]) begin
      next_high = 1'b1;
    end else if (s < thr_low[ch]) begin
      next_high = 1'b0;
    end
    if (next_high && n_samp_m[ch] < `CAP_DATA_DEPTH) begin
      // burst start, timer and saved count before this sample
      if (!is_high_m[ch] && n_ts_m[ch] < `CAP_TS_DEPTH) begin
        exp_ts[ch][n_ts_m[ch]] = {timer_m[ch][23:0], n_samp_m[ch][7:0]};
        n_ts_m[ch]++;
      end
      exp_data[ch][n_samp_m[ch]] = s;
      n_samp_m[ch]++;
    end
    is_high_m[ch] = next_high;
    timer_m[ch]++;
  endfunction

  // timestamp phase then data phase, channel word, count word, entries
  function automatic void build_expected();
    int ch;
    int k;
    n_exp = 0;
    for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
      exp_words[n_exp++] = 32'(ch);
      exp_words[n_exp++] = 32'(n_ts_m[ch]);
      for (k = 0; k < n_ts_m[ch]; k++) begin
        exp_words[n_exp++] = exp_ts[ch][k];
      end
    end
    for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
      exp_words[n_exp++] = 32'(ch);
      exp_words[n_exp++] = 32'(n_samp_m[ch]);
      for (k = 0; k < n_samp_m[ch]; k++) begin
        exp_words[n_exp++] = {16'h0000, exp_data[ch][k]};
      end
    end
  endfunction

  //////////////////////////////
  // one capture and readout
  //////////////////////////////
  task automatic run_trial(input int mode, input int n_beats);
    logic [15:0] smp;
    logic        vld;
    logic [31:0] got;
    int          b;
    int          ch;
    int          i;
    // thresholds per channel, shaped by the mode
    for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
      case (mode)
        M_ALL_HIGH: begin
          thr_high[ch] = take_bits(12);
          thr_low[ch] = 16'h0000;
        end
        M_ALL_LOW: begin
          thr_low[ch] = 16'h4000 + take_bits(12);
          thr_high[ch] = thr_low[ch] + 16'h1000;
        end
        default: begin
          thr_high[ch] = 16'h9000 + take_bits(10);
          thr_low[ch] = 16'h6000 + take_bits(10);
        end
      endcase
    end
    bus_write(A_THRESH0, {thr_high[0], thr_low[0]});
    bus_write(A_THRESH1, {thr_high[1], thr_low[1]});
    bus_write(A_CONTROL, 32'h1);
    wait_state(ST_CAPTURE);
    model_clear();
    for (b = 0; b < n_beats; b++) begin
      @(negedge clk);
      for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
        case (mode)
          M_ALL_HIGH: smp = 16'h1000 + take_bits(15);
          M_ALL_LOW:  smp = take_bits(14);
          default:    smp = take_bits(16);
        endcase
        // about one beat in four is idle in the gap mode
        vld = (mode == M_GAPS) ? (take_bits(2) != 16'd0) : 1'b1;
        sample_in[ch].valid = vld;
        sample_in[ch].sample = smp;
        if (vld) begin
          model_sample(ch, smp);
        end
      end
    end
    @(negedge clk);
    for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
      sample_in[ch].valid = 1'b0;
    end
    bus_write(A_CONTROL, 32'h2);
    wait_state(ST_READ_TS);
    build_expected();
    for (i = 0; i < n_exp; i++) begin
      bus_read(A_READOUT, got);
      check_value(got, exp_words[i], $sformatf("mode %0d readout word %0d", mode, i));
    end
    bus_read(A_STATUS, got);
    check_value(got, 32'(ST_DONE), "status after the last readout word");
    bus_read(A_READOUT, got);
    check_value(got, 32'd0, "readout read in done state");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    logic [31:0] got;
    logic [31:0] thr_word;
    int          ch;
    clk = 1'b0;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    for (ch = 0; ch < `CAP_N_CHANNELS; ch++) begin
      sample_in[ch] = '0;
    end
    lfsr_q = 16'd94;
    errors = 0;
    n_exp = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // registers out of reset
    bus_read(A_STATUS, got);
    check_value(got, 32'(ST_IDLE), "status after reset");
    bus_read(A_THRESH0, got);
    check_value(got, 32'd0, "channel 0 thresholds after reset");
    bus_read(A_THRESH1, got);
    check_value(got, 32'd0, "channel 1 thresholds after reset");

    // threshold write and readback
    thr_word = {take_bits(16), take_bits(16)};
    bus_write(A_THRESH0, thr_word);
    bus_read(A_THRESH0, got);
    check_value(got, thr_word, "channel 0 threshold readback");
    thr_word = {take_bits(16), take_bits(16)};
    bus_write(A_THRESH1, thr_word);
    bus_read(A_THRESH1, got);
    check_value(got, thr_word, "channel 1 threshold readback");

    // each later trial restarts from done, fresh timer and counts
    run_trial(M_ALL_HIGH, 40);
    run_trial(M_ALL_LOW, 30);
    run_trial(M_STRADDLE, 150);
    run_trial(M_GAPS, 150);
    run_trial(M_STRADDLE, 60);

    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sparse_capture.f ====
+incdir+rtl
rtl/capture_pkg.sv
rtl/hysteresis_discriminator.sv
rtl/channel_buffer.sv
rtl/readout_counter.sv
rtl/capture_control.sv
rtl/wb_capture_regs.sv
rtl/sparse_capture_top.sv
tb/tb_sparse_capture.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the sparse capture testbench with verilator, run it, check the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_sparse_capture \
  -f sparse_capture.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
